// File: design/segPkg.sv
`default_nettype none

package segPkg;

	// ================================================
	// display widths
	// ================================================

	// four nibbles, digit 0 sits in the low nibble
	typedef logic [15:0] hexValue_t;

	// one bit per digit, shared by the dp and enable masks
	typedef logic [3:0] digitMask_t;

	// active low, bit 7 is the decimal point, bits 6..0 are g..a
	typedef logic [7:0] segBits_t;

	// active low anode lines, one per digit
	typedef logic [3:0] anodeBits_t;

	// scan slot 0..7, only 0..3 light a digit
	typedef logic [2:0] slotIdx_t;

	// all lines high means nothing lit
	localparam segBits_t SegOff = 8'hFF;
	localparam anodeBits_t AnodeOff = 4'hF;

	// ================================================
	// host register map
	// ================================================

	typedef logic [1:0] regAddr_t;
	typedef logic [15:0] regData_t;

	// address 3 is unused and reads back zero
	localparam regAddr_t RegValue = 2'd0;
	localparam regAddr_t RegDp = 2'd1;
	localparam regAddr_t RegDigitOn = 2'd2;

	// stored configuration, 24 bits
	typedef struct packed {
		hexValue_t value;
		digitMask_t dp;
		digitMask_t digitOn;
	} dispCfg_t;

	// current scan position
	typedef struct packed {
		slotIdx_t slot;
		logic blank;
	} scanPos_t;

	// ================================================
	// scan timing
	// ================================================

	// top 3 bits pick the slot, 512 counts per slot
	localparam int unsigned ScanCountW = 12;
	localparam int unsigned DefaultClkFreq = 25_000_000;
	localparam int unsigned ScanTickFreq = 250_000;
	localparam int unsigned DefaultTickDiv = DefaultClkFreq / ScanTickFreq;

endpackage

`default_nettype wire

// File: design/scanTimer.sv
`default_nettype none

module scanTimer #(
	parameter int unsigned tickDiv = segPkg::DefaultTickDiv
) (
	input logic clk,
	input logic arstN,
	output segPkg::scanPos_t pos
);

	import segPkg::*;

	// prescaler wide enough for tickDiv-1, never narrower than one bit
	localparam int unsigned PreW = (tickDiv > 1) ? $clog2(tickDiv) : 1;
	localparam logic [PreW-1:0] PreLoad = PreW'(tickDiv - 1);

	logic [PreW-1:0] prescale;
	logic tick;
	logic [ScanCountW-1:0] scanCnt;

	// ================================================
	// prescaler
	// ================================================

	// tick is high for the one cycle the down counter sits at zero
	assign tick = (prescale == '0);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			prescale <= PreLoad;
		end else if (tick) begin
			// reload so ticks repeat every tickDiv cycles
			prescale <= PreLoad;
		end else begin
			prescale <= prescale - 1'b1;
		end
	end

	// ================================================
	// scan counter
	// ================================================

	// free running, wraps at 4096 to restart the frame
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			scanCnt <= '0;
		end else if (tick) begin
			scanCnt <= scanCnt + 1'b1;
		end
	end

	// slot from the top three bits
	assign pos.slot = scanCnt[ScanCountW-1 -: 3];

	// blank for the last two counts of each 512-count slot
	assign pos.blank = &scanCnt[ScanCountW-4:1];

	// ================================================
	// checks
	// ================================================

	// reload value bounds the down counter across all time
	property pPrescaleBound;
		@(posedge clk) disable iff (!arstN)
		prescale <= PreLoad;
	endproperty

	aPrescaleBound : assert property (pPrescaleBound)
		else $error("scanTimer prescaler above tickDiv-1: %0d", prescale);

endmodule

`default_nettype wire

// File: design/dispRegs.sv
`default_nettype none

module dispRegs (
	input logic clk,
	input logic arstN,
	input logic wrEn,
	input segPkg::regAddr_t wrAddr,
	input segPkg::regData_t wrData,
	input segPkg::regAddr_t rdAddr,
	output segPkg::regData_t rdData,
	output segPkg::dispCfg_t cfg
);

	import segPkg::*;

	// per-register write strobes
	logic wrValue;
	logic wrDp;
	logic wrDigitOn;

	// ================================================
	// write decode
	// ================================================

	assign wrValue = wrEn && (wrAddr == RegValue);
	assign wrDp = wrEn && (wrAddr == RegDp);
	assign wrDigitOn = wrEn && (wrAddr == RegDigitOn);

	// ================================================
	// configuration registers
	// ================================================

	// hex value, blank zero display after reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			cfg.value <= '0;
		end else if (wrValue) begin
			cfg.value <= wrData;
		end
	end

	// decimal points, low nibble of the write data only
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			cfg.dp <= '0;
		end else if (wrDp) begin
			cfg.dp <= wrData[3:0];
		end
	end

	// digit enables, every digit on after reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			cfg.digitOn <= '1;
		end else if (wrDigitOn) begin
			cfg.digitOn <= wrData[3:0];
		end
	end

	// ================================================
	// readback
	// ================================================

	// combinational, masks come back zero extended
	always_comb begin
		unique case (rdAddr)
			RegValue: rdData = cfg.value;
			RegDp: rdData = regData_t'(cfg.dp);
			RegDigitOn: rdData = regData_t'(cfg.digitOn);
			default: rdData = '0;
		endcase
	end

	// a write with an unknown address would corrupt some register silently
	property pWrAddrKnown;
		@(posedge clk) disable iff (!arstN)
		wrEn |-> !$isunknown(wrAddr);
	endproperty

	aWrAddrKnown : assert property (pWrAddrKnown)
		else $error("dispRegs write with unknown address");

endmodule

`default_nettype wire

// File: design/segDriver.sv
`default_nettype none

module segDriver (
	input segPkg::scanPos_t pos,
	input segPkg::dispCfg_t cfg,
	output segPkg::anodeBits_t ssLedAnode,
	output segPkg::segBits_t ssLedSeg
);

	import segPkg::*;

	// digit index within the lit half of the scan
	logic [1:0] digitIdx;
	logic [3:0] nibble;
	logic dpOn;
	logic lit;

	// ================================================
	// hex decode
	// ================================================

	// active low patterns, bit 7 left high here
	function automatic segBits_t hexToSeg(input logic [3:0] nib);
		segBits_t pat;
		unique case (nib)
			4'h0: pat = 8'hC0;
			4'h1: pat = 8'hF9;
			4'h2: pat = 8'hA4;
			4'h3: pat = 8'hB0;
			4'h4: pat = 8'h99;
			4'h5: pat = 8'h92;
			4'h6: pat = 8'h82;
			4'h7: pat = 8'hF8;
			4'h8: pat = 8'h80;
			4'h9: pat = 8'h98;
			4'hA: pat = 8'h88;
			// lower case b so it differs from 8
			4'hB: pat = 8'h83;
			4'hC: pat = 8'hC6;
			// lower case d so it differs from 0
			4'hD: pat = 8'hA1;
			4'hE: pat = 8'h86;
			default: pat = 8'h8E;
		endcase
		return pat;
	endfunction

	// ================================================
	// slot select
	// ================================================

	assign digitIdx = pos.slot[1:0];

	// nibble and decimal point of the digit in this slot
	assign nibble = cfg.value[digitIdx*4 +: 4];
	assign dpOn = cfg.dp[digitIdx];

	// slots 4..7 stay dark, as do blanked counts and disabled digits
	assign lit = !pos.slot[2] && !pos.blank && cfg.digitOn[digitIdx];

	// ================================================
	// pin drive
	// ================================================

	always_comb begin
		ssLedAnode = AnodeOff;
		ssLedSeg = SegOff;
		if (lit) begin
			// pull the one anode of this digit low
			ssLedAnode = ~(anodeBits_t'(1) << digitIdx);
			ssLedSeg = hexToSeg(nibble);
			// decimal point is active low as well
			ssLedSeg[7] = !dpOn;
		end
	end

	// ================================================
	// checks
	// ================================================

	// never two digits at once, and nothing lit outside slots 0..3
	always_comb begin
		aOneAnode : assert #0 ($onehot0(~ssLedAnode)
				&& ((ssLedAnode == AnodeOff) || !pos.slot[2]))
			else $error("segDriver anode lines invalid: %b", ssLedAnode);
	end

endmodule

`default_nettype wire

// File: design/segDisplay.sv
`default_nettype none

module segDisplay #(
	parameter int unsigned tickDiv = segPkg::DefaultTickDiv
) (
	input logic clk,
	input logic arstN,
	// host register port
	input logic wrEn,
	input segPkg::regAddr_t wrAddr,
	input segPkg::regData_t wrData,
	input segPkg::regAddr_t rdAddr,
	output segPkg::regData_t rdData,
	// display pins, all active low
	output segPkg::anodeBits_t ssLedAnode,
	output segPkg::segBits_t ssLedSeg
);

	import segPkg::*;

	// registered configuration and scan position
	dispCfg_t cfg;
	scanPos_t pos;

	// ================================================
	// scan timing
	// ================================================

	scanTimer #(
		.tickDiv(tickDiv)
	) uScanTimer (
		.clk(clk),
		.arstN(arstN),
		.pos(pos)
	);

	// ================================================
	// host registers
	// ================================================

	dispRegs uDispRegs (
		.clk(clk),
		.arstN(arstN),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdAddr(rdAddr),
		.rdData(rdData),
		.cfg(cfg)
	);

	// combinational from cfg and pos, so pins follow a write by one cycle
	segDriver uSegDriver (
		.pos(pos),
		.cfg(cfg),
		.ssLedAnode(ssLedAnode),
		.ssLedSeg(ssLedSeg)
	);

endmodule

`default_nettype wire

// File: tests/segDisplayTb.sv
`default_nettype none

module segDisplayTb;

	timeunit 1ns;
	timeprecision 100ps;

	import segPkg::*;

	// ================================================
	// setup
	// ================================================

	// small divisor, one frame is 4096 ticks of 2 cycles
	localparam int TickDiv = 2;
	localparam int FrameCycles = 4096 * TickDiv;

	// stimulus modes for one clock cycle
	localparam int ModeIdle = 0;
	localparam int ModeHex = 1;
	localparam int ModeEnable = 2;

	// standard active-low hex patterns, dp bit left high
	localparam segBits_t HexTable [16] = '{
		8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
		8'h80, 8'h98, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
	};

	// readback right after reset, indexed by address
	localparam regData_t ResetRead [4] = '{16'h0000, 16'h0000, 16'h000F, 16'h0000};

	logic clk;
	logic arstN;
	logic wrEn;
	regAddr_t wrAddr;
	regData_t wrData;
	regAddr_t rdAddr;
	regData_t rdData;
	anodeBits_t ssLedAnode;
	segBits_t ssLedSeg;

	integer seed;
	string testName;

	// model of prescaler, scan count and register shadow
	int mPre;
	int mCnt;
	int mFrames;
	hexValue_t mValue;
	digitMask_t mDp;
	digitMask_t mDigitOn;

	segDisplay #(
		.tickDiv(TickDiv)
	) dut (
		.clk(clk),
		.arstN(arstN),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdAddr(rdAddr),
		.rdData(rdData),
		.ssLedAnode(ssLedAnode),
		.ssLedSeg(ssLedSeg)
	);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ================================================
	// model
	// ================================================

	// one rising edge, using the inputs that were held across it
	task automatic updateModel();
		if (!arstN) begin
			mPre = TickDiv - 1;
			mCnt = 0;
			mValue = '0;
			mDp = '0;
			mDigitOn = '1;
		end else begin
			if (wrEn) begin
				if (wrAddr == RegValue) begin
					mValue = wrData;
				end else if (wrAddr == RegDp) begin
					mDp = wrData[3:0];
				end else if (wrAddr == RegDigitOn) begin
					mDigitOn = wrData[3:0];
				end
			end
			// tick on the edge where the down counter sits at zero
			if (mPre == 0) begin
				mPre = TickDiv - 1;
				mCnt = (mCnt + 1) % 4096;
				if (mCnt == 0) begin
					mFrames++;
				end
			end else begin
				mPre = mPre - 1;
			end
		end
	endtask

	function automatic regData_t modelRead(input regAddr_t addr);
		regData_t data;
		case (addr)
			RegValue: data = mValue;
			RegDp: data = {12'h000, mDp};
			RegDigitOn: data = {12'h000, mDigitOn};
			default: data = '0;
		endcase
		return data;
	endfunction

	// 512 counts per slot, last two counts of each slot are dark
	function automatic logic modelLit();
		int slot;
		slot = mCnt / 512;
		if (slot >= 4 || (mCnt % 512) >= 510) begin
			return 1'b0;
		end
		return mDigitOn[slot];
	endfunction

	function automatic anodeBits_t expAnode();
		anodeBits_t a;
		a = 4'hF;
		if (modelLit()) begin
			a[mCnt / 512] = 1'b0;
		end
		return a;
	endfunction

	function automatic segBits_t expSeg();
		segBits_t s;
		hexValue_t shifted;
		int slot;
		slot = mCnt / 512;
		s = 8'hFF;
		if (modelLit()) begin
			shifted = mValue >> (4 * slot);
			s = HexTable[shifted[3:0]];
			s[7] = !mDp[slot];
		end
		return s;
	endfunction

	// ================================================
	// compare tasks
	// ================================================

	task automatic checkAnode(input string name, input anodeBits_t expected,
			input anodeBits_t actual);
		if (actual !== expected) begin
			$display("ERROR %s: anode expected %b, actual %b at %0t", name, expected,
				actual, $time);
			$display("Finished with errors");
			$fatal(1, "anode lines differ from the model");
		end
	endtask

	task automatic checkSeg(input string name, input segBits_t expected,
			input segBits_t actual);
		if (actual !== expected) begin
			$display("ERROR %s: segments expected %h, actual %h at %0t", name, expected,
				actual, $time);
			$display("Finished with errors");
			$fatal(1, "segment lines differ from the model");
		end
	endtask

	task automatic checkRead(input string name, input regData_t expected,
			input regData_t actual);
		if (actual !== expected) begin
			$display("ERROR %s: read expected %h, actual %h at %0t", name, expected,
				actual, $time);
			$display("Finished with errors");
			$fatal(1, "register readback differs from the model");
		end
	endtask

	// ================================================
	// stimulus
	// ================================================

	function automatic regData_t randomData();
		int v;
		v = $random(seed);
		return v[15:0];
	endfunction

	// step one cycle, drive 2 ns after the edge, check pins mid cycle
	task automatic runCycle(input int mode, input int rdSel);
		int r;
		@(posedge clk);
		updateModel();
		#2;
		r = $random(seed);
		wrEn = 1'b0;
		if (mode == ModeHex && r[5:0] == 6'd0) begin
			wrEn = 1'b1;
			// mostly value and dp, sometimes the unused address
			case (r[9:8])
				2'd0, 2'd1: wrAddr = RegValue;
				2'd2: wrAddr = RegDp;
				default: wrAddr = 2'd3;
			endcase
			wrData = randomData();
		end else if (mode == ModeEnable && r[5:0] == 6'd0) begin
			wrEn = 1'b1;
			wrAddr = (r[9:8] == 2'd0) ? RegValue : RegDigitOn;
			// all digits off now and then
			wrData = (r[11:10] == 2'd0) ? 16'h0000 : randomData();
		end
		if (rdSel >= 0) begin
			rdAddr = regAddr_t'(rdSel);
		end else begin
			rdAddr = r[13:12];
		end
		#8;
		checkAnode(testName, expAnode(), ssLedAnode);
		checkSeg(testName, expSeg(), ssLedSeg);
		checkRead({testName, " readback"}, modelRead(rdAddr), rdData);
	endtask

	task automatic waitFirstTick();
		int cycles;
		cycles = 0;
		while (mCnt == 0) begin
			if (cycles >= 4 * TickDiv + 8) begin
				$display("Finished with errors");
				$fatal(1, "timed out waiting for the first scan tick");
			end
			runCycle(ModeIdle, -1);
			cycles++;
		end
	endtask

	// run until the model has wrapped the scan count count times
	task automatic runFrames(input int count, input int mode);
		int target;
		int cycles;
		target = mFrames + count;
		cycles = 0;
		while (mFrames < target) begin
			if (cycles >= count * FrameCycles + 64) begin
				$display("Finished with errors");
				$fatal(1, "timed out waiting for the end of a scan frame");
			end
			runCycle(mode, -1);
			cycles++;
		end
	endtask

	// ================================================
	// test sequence
	// ================================================

	initial begin
		seed = 32'hf8a4_b63b;
		arstN = 1'b0;
		wrEn = 1'b0;
		wrAddr = '0;
		wrData = '0;
		rdAddr = '0;
		mFrames = 0;
		testName = "reset";
		updateModel();

		// reset held across two rising edges
		repeat (2) begin
			@(posedge clk);
			updateModel();
		end
		#2;
		arstN = 1'b1;

		testName = "first tick";
		waitFirstTick();

		// reset values on every address, slot 0 showing zero
		testName = "reset values";
		for (int a = 0; a < 4; a++) begin
			runCycle(ModeIdle, a);
			checkRead(testName, ResetRead[a], rdData);
		end

		// finish frame 0 so the next phase starts on a frame boundary
		testName = "frame align";
		runFrames(1, ModeIdle);

		testName = "scan sequence";
		runFrames(2, ModeIdle);

		testName = "hex decode";
		runFrames(3, ModeHex);

		testName = "digit enables";
		runFrames(3, ModeEnable);

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: segDisplay.f
design/segPkg.sv
design/scanTimer.sv
design/dispRegs.sv
design/segDriver.sv
design/segDisplay.sv
tests/segDisplayTb.sv

// File: Makefile
# Verilator build and run for the seven-segment display testbench
# override any variable on the command line, e.g. make BUILD_DIR=build

VERILATOR ?= verilator
TOP ?= segDisplayTb
FILELIST ?= segDisplay.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS ?= --binary --timing --assert --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only -Wall --timing --timescale $(TIMESCALE)

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulation is the test result
run: $(SIM)
	./$(SIM)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
